//--- sources.f
hdl/ctrl_pkg.sv
hdl/hazard_detect.sv
hdl/operand_forward.sv
hdl/ctrl_fsm.sv
hdl/core_controller.sv
verification/core_controller_asserts.sv
verification/tb_core_controller.sv

//--- verification/tb_core_controller.sv
// random testbench for the core controller with LFSR driven inputs in phases,
// checked each cycle against a reference model of the FSM, hazards and forwarding
`timescale 1ns/100ps
`default_nettype none

module tb_core_controller;

  import ctrl_pkg::*;

  localparam int      N_OP         = 3;
  localparam int      N_PHASES     = 6;
  localparam int      PHASE_LEN    = 320;
  localparam int      TOTAL_CYCLES = 3 + N_PHASES * PHASE_LEN;
  localparam realtime T_CLK        = 4.0;
  localparam realtime DRIVE_DLY    = 0.5;
  localparam realtime CHECK_DLY    = 2.5;
  localparam realtime TIMEOUT      = (TOTAL_CYCLES + 100) * T_CLK;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic fetch_enable_i, instr_valid_i, branch_taken_ex_i, eret_insn_i;
  logic pipe_flush_i, illegal_insn_i, exc_req_i, ext_req_i;
  logic id_ready_i, ex_valid_i, data_req_ex_i, data_misaligned_i, mult_multicycle_i;
  logic regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic [N_OP-1:0] reg_d_ex_match_i, reg_d_wb_match_i, reg_d_alu_match_i;
  jump_e jump_in_dec_i;

  // DUT outputs
  logic ctrl_busy_o, is_decoding_o, instr_req_o, pc_set_o, exc_ack_o;
  logic exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o, exc_restore_id_o;
  logic halt_if_o, halt_id_o, load_stall_o, jr_stall_o, deassert_we_o;
  pc_mux_e pc_mux_o;
  fw_sel_e [N_OP-1:0] operand_fw_sel_o;

  // reference model state and expected outputs
  ctrl_state_e mdl_state;
  ctrl_state_e nxt_state;
  logic mdl_jd, nxt_jd;
  logic e_busy, e_dec, e_req, e_set, e_ack, e_sif, e_sid, e_stb, e_rid, e_hif, e_hid;
  logic e_load, e_jr, e_dwe;
  pc_mux_e e_mux;
  fw_sel_e [N_OP-1:0] e_fw;

  int error_count = 0;
  int check_count = 0;
  logic [31:0] lfsr = 32'h770b_0ce0;

  // odds out of 16 for each phase and input
  // fetch_en id_ready jump exc_req ext_req flush eret branch ex_valid
  int odds [N_PHASES][9] = '{
    '{ 3,  8,  4, 1, 1, 0, 0, 2, 8},  // boot
    '{15, 12,  3, 1, 1, 0, 0, 3, 8},  // forwarding and hazards
    '{15,  2, 12, 1, 1, 0, 0, 1, 8},  // held jumps while ID stalls
    '{15,  8,  3, 6, 6, 0, 4, 4, 8},  // exceptions and eret
    '{ 8,  8,  3, 1, 1, 3, 2, 2, 5},  // flush and sleep
    '{12, 10,  4, 3, 3, 1, 2, 3, 8}   // everything mixed
  };

  core_controller #(.N_OPERANDS(N_OP)) dut0 (.*);

  bind core_controller core_controller_asserts u_asserts (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .ctrl_busy_i       (ctrl_busy_o),
    .halt_if_i         (halt_if_o),
    .instr_req_i       (instr_req_o),
    .pc_set_i          (pc_set_o),
    .pc_mux_i          (pc_mux_o),
    .exc_ack_i         (exc_ack_o)
  );

  initial begin
    clk = 1'b0;
    forever #(T_CLK / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////////

  // fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[6:0], fb};
    end
    return r;
  endfunction

  // true with n16 out of 16
  function automatic logic chance(input int n16);
    return (take_bits(4) < n16);
  endfunction

  task automatic drive_inputs(input int p);
    logic [7:0] r;
    logic bt;
    fetch_enable_i = chance(odds[p][0]);
    id_ready_i     = chance(odds[p][1]);
    r              = take_bits(2);
    jump_in_dec_i  = chance(odds[p][2]) ? jump_e'(r[1:0]) : BRANCH_NONE;
    exc_req_i      = chance(odds[p][3]);
    ext_req_i      = chance(odds[p][4]);
    pipe_flush_i   = chance(odds[p][5]);
    eret_insn_i    = chance(odds[p][6]);
    // never two taken branches back to back in the shadow
    bt                = chance(odds[p][7]);
    branch_taken_ex_i = bt & ~branch_taken_ex_i;
    ex_valid_i        = chance(odds[p][8]);
    instr_valid_i     = chance(13);
    illegal_insn_i    = chance(1);
    data_req_ex_i     = chance(6);
    data_misaligned_i = chance(3);
    mult_multicycle_i = chance(4);
    regfile_we_ex_i     = chance(8);
    regfile_we_wb_i     = chance(8);
    regfile_alu_we_fw_i = chance(8);
    r = take_bits(N_OP);
    reg_d_ex_match_i  = r[N_OP-1:0];
    r = take_bits(N_OP);
    reg_d_wb_match_i  = r[N_OP-1:0];
    r = take_bits(N_OP);
    reg_d_alu_match_i = r[N_OP-1:0];
  endtask

  //////////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////////

  task automatic predict();
    logic valid;
    logic is_jump;
    logic ex_load;
    // hazards first since the jump redirect depends on jr stall
    // a load in EX blocks any operand that reads its destination
    ex_load = data_req_ex_i && regfile_we_ex_i;
    e_load  = 1'b0;
    for (int k = 0; k < N_OP; k++) begin
      if (ex_load && reg_d_ex_match_i[k])
        e_load = 1'b1;
    end
    // a jalr waits for any write still pending on operand A
    e_jr = 1'b0;
    if (jump_in_dec_i == BRANCH_JALR) begin
      if (regfile_we_wb_i && reg_d_wb_match_i[0])
        e_jr = 1'b1;
      if (regfile_we_ex_i && reg_d_ex_match_i[0])
        e_jr = 1'b1;
      if (regfile_alu_we_fw_i && reg_d_alu_match_i[0])
        e_jr = 1'b1;
    end
    // newest writer wins and the overrides go on top
    for (int k = 0; k < N_OP; k++) begin
      e_fw[k] = SEL_REGFILE;
      if (regfile_we_wb_i && reg_d_wb_match_i[k])
        e_fw[k] = SEL_FW_WB;
      if (regfile_alu_we_fw_i && reg_d_alu_match_i[k])
        e_fw[k] = SEL_FW_EX;
    end
    if (data_misaligned_i) begin
      e_fw[0] = SEL_FW_EX;
      e_fw[1] = SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      e_fw[2] = SEL_FW_EX;
    end
    // busy and fetching unless idle with nothing redirected
    {e_busy, e_req, e_dec, e_set, e_ack} = 5'b11000;
    {e_sif, e_sid, e_stb, e_rid, e_hif, e_hid} = '0;
    e_mux     = PC_BOOT;
    nxt_state = mdl_state;
    nxt_jd    = mdl_jd;
    valid     = instr_valid_i && !branch_taken_ex_i;
    is_jump   = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);
    case (mdl_state)
      RESET: begin
        {e_busy, e_req} = 2'b00;
        if (fetch_enable_i)
          nxt_state = BOOT_SET;
      end
      BOOT_SET: begin
        e_set     = 1'b1;
        nxt_state = FIRST_FETCH;
      end
      SLEEP: begin
        {e_busy, e_req, e_hif, e_hid} = 4'b0011;
        if (fetch_enable_i || exc_req_i)
          nxt_state = FIRST_FETCH;
      end
      FIRST_FETCH: begin
        if (id_ready_i)
          nxt_state = DECODE;
        if (exc_req_i) begin
          {e_set, e_ack, e_sif} = 3'b111;
          e_mux = PC_EXCEPTION;
        end
      end
      DECODE: begin
        e_dec = valid;
        // one redirect per jump held off by a jr stall
        if (valid && is_jump) begin
          e_mux = PC_JUMP;
          if (!e_jr && !mdl_jd)
            {e_set, nxt_jd} = 2'b11;
        end
        if (valid && !is_jump && exc_req_i) begin
          {e_set, e_ack, e_sid, e_hid} = 4'b1111;
          e_mux = PC_EXCEPTION;
        end
        if (valid && eret_insn_i) begin
          e_mux = PC_ERET;
          e_rid = 1'b1;
          if (!mdl_jd)
            {e_set, nxt_jd} = 2'b11;
        end
        if (valid && (pipe_flush_i || (eret_insn_i && !fetch_enable_i))) begin
          {e_hif, e_hid} = 2'b11;
          nxt_state = FLUSH_EX;
        end
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          {e_set, e_ack, e_sif, e_hid} = 4'b1111;
          e_mux = PC_EXCEPTION;
        end
        if (branch_taken_ex_i) begin
          e_set = 1'b1;
          e_dec = 1'b0;
          e_mux = ext_req_i ? PC_EXCEPTION : PC_BRANCH;
          if (ext_req_i)
            {e_ack, e_stb, e_hid} = 3'b111;
        end
      end
      FLUSH_EX: begin
        {e_hif, e_hid} = 2'b11;
        if (ex_valid_i)
          nxt_state = FLUSH_WB;
      end
      FLUSH_WB: begin
        {e_hif, e_hid} = {~fetch_enable_i, 1'b1};
        nxt_state = fetch_enable_i ? DECODE : SLEEP;
      end
      default: nxt_state = RESET;
    endcase
    // jump flag clears once ID takes the next instruction
    nxt_jd = nxt_jd & ~id_ready_i;
    e_dwe  = ~e_dec | illegal_insn_i | e_load | e_jr;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("FAILED %s expected %0h actual %0h at %0t", name, exp, act, $realtime);
    end
  endtask

  task automatic check_outputs();
    check_value("ctrl_busy_o", e_busy, ctrl_busy_o);
    check_value("is_decoding_o", e_dec, is_decoding_o);
    check_value("instr_req_o", e_req, instr_req_o);
    check_value("pc_set_o", e_set, pc_set_o);
    check_value("pc_mux_o", e_mux, pc_mux_o);
    check_value("exc_ack_o", e_ack, exc_ack_o);
    check_value("exc_save_if_o", e_sif, exc_save_if_o);
    check_value("exc_save_id_o", e_sid, exc_save_id_o);
    check_value("exc_save_takenbranch_o", e_stb, exc_save_takenbranch_o);
    check_value("exc_restore_id_o", e_rid, exc_restore_id_o);
    check_value("halt_if_o", e_hif, halt_if_o);
    check_value("halt_id_o", e_hid, halt_id_o);
    check_value("load_stall_o", e_load, load_stall_o);
    check_value("jr_stall_o", e_jr, jr_stall_o);
    check_value("deassert_we_o", e_dwe, deassert_we_o);
    for (int k = 0; k < N_OP; k++)
      check_value($sformatf("operand_fw_sel_o[%0d]", k), e_fw[k], operand_fw_sel_o[k]);
  endtask

  initial begin
    rst_n = 1'b0;
    {fetch_enable_i, instr_valid_i, branch_taken_ex_i, eret_insn_i} = '0;
    {pipe_flush_i, illegal_insn_i, exc_req_i, ext_req_i} = '0;
    {id_ready_i, ex_valid_i, data_req_ex_i, data_misaligned_i, mult_multicycle_i} = '0;
    {regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i} = '0;
    {reg_d_ex_match_i, reg_d_wb_match_i, reg_d_alu_match_i} = '0;
    jump_in_dec_i = BRANCH_NONE;
    mdl_state     = RESET;
    mdl_jd        = 1'b0;
    repeat (3) @(posedge clk);
    // one drive and one check per cycle while the model steps with the DUT
    for (int p = 0; p < N_PHASES; p++) begin
      for (int c = 0; c < PHASE_LEN; c++) begin
        #(DRIVE_DLY);
        rst_n = 1'b1;
        drive_inputs(p);
        #(CHECK_DLY);
        predict();
        check_outputs();
        mdl_state = nxt_state;
        mdl_jd    = nxt_jd;
        @(posedge clk);
      end
    end
    $display("checks %0d, errors %0d, assertion failures %0d",
             check_count, error_count, dut0.u_asserts.fail_count);
    if (error_count == 0 && dut0.u_asserts.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // a late end means the DUT or bench is stuck
  initial begin
    #(TIMEOUT);
    $display("timeout: the run did not complete within the expected time");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/core_controller_asserts.sv
// concurrent checks on the core controller ports, bound into the top level
// by the testbench. failures are counted for the closing report
`timescale 1ns/100ps
`default_nettype none

module core_controller_asserts (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        fetch_enable_i,
  input  wire logic        branch_taken_ex_i,
  input  wire logic        ctrl_busy_i,
  input  wire logic        halt_if_i,
  input  wire logic        instr_req_i,
  input  wire logic        pc_set_i,
  input  ctrl_pkg::pc_mux_e pc_mux_i,
  input  wire logic        exc_ack_i
);

  import ctrl_pkg::*;

  // number of failed assertions, read at the end of the run
  int fail_count = 0;

  // idle with no halts only happens in the reset state
  // fetch enable there leads into the single boot cycle
  a_boot_set : assert property (@(posedge clk) disable iff (!rst_n)
    (!ctrl_busy_i && !halt_if_i && fetch_enable_i) |=> (pc_set_i && pc_mux_i == PC_BOOT))
    else begin
      fail_count++;
      $error("boot cycle after reset has no pc_set with the boot address");
    end

  // every acknowledged exception redirects fetch
  a_ack_sets_pc : assert property (@(posedge clk) disable iff (!rst_n)
    exc_ack_i |-> pc_set_i)
    else begin
      fail_count++;
      $error("exc_ack without pc_set");
    end

  // no fetch requests while the controller is idle
  a_idle_no_req : assert property (@(posedge clk) disable iff (!rst_n)
    !ctrl_busy_i |-> !instr_req_i)
    else begin
      fail_count++;
      $error("instr_req while controller not busy");
    end

  // a taken branch is followed by its shadow, never another branch
  a_branch_gap : assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else begin
      fail_count++;
      $error("taken branch in two consecutive cycles");
    end

endmodule

`default_nettype wire

//--- hdl/core_controller.sv
// core controller top: control FSM, ID hazard detection and operand
// forwarding select, wired to the decode stage of the core
`timescale 1ns/100ps
`default_nettype none

module core_controller #(
  parameter int N_OPERANDS = ctrl_pkg::N_OPERANDS
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,

  // fetch and decode status
  input  wire logic                          fetch_enable_i,
  input  wire logic                          instr_valid_i,
  input  wire logic                          branch_taken_ex_i,
  input  ctrl_pkg::jump_e                    jump_in_dec_i,
  input  wire logic                          eret_insn_i,
  input  wire logic                          pipe_flush_i,
  input  wire logic                          illegal_insn_i,

  // exception requests
  input  wire logic                          exc_req_i,
  input  wire logic                          ext_req_i,

  // pipeline progress
  input  wire logic                          id_ready_i,
  input  wire logic                          ex_valid_i,

  // LSU and multiplier state
  input  wire logic                          data_req_ex_i,
  input  wire logic                          data_misaligned_i,
  input  wire logic                          mult_multicycle_i,

  // pending register writes and destination matches
  input  wire logic                          regfile_we_ex_i,
  input  wire logic                          regfile_we_wb_i,
  input  wire logic                          regfile_alu_we_fw_i,
  input  wire logic [N_OPERANDS-1:0]         reg_d_ex_match_i,
  input  wire logic [N_OPERANDS-1:0]         reg_d_wb_match_i,
  input  wire logic [N_OPERANDS-1:0]         reg_d_alu_match_i,

  // FSM outputs
  output logic                               ctrl_busy_o,
  output logic                               is_decoding_o,
  output logic                               instr_req_o,
  output logic                               pc_set_o,
  output ctrl_pkg::pc_mux_e                  pc_mux_o,
  output logic                               exc_ack_o,
  output logic                               exc_save_if_o,
  output logic                               exc_save_id_o,
  output logic                               exc_save_takenbranch_o,
  output logic                               exc_restore_id_o,
  output logic                               halt_if_o,
  output logic                               halt_id_o,

  // hazards and forwarding
  output logic                               load_stall_o,
  output logic                               jr_stall_o,
  output logic                               deassert_we_o,
  output ctrl_pkg::fw_sel_e [N_OPERANDS-1:0] operand_fw_sel_o
);

  // jr_stall_o feeds the FSM, is_decoding_o feeds the hazard unit
  ctrl_fsm u_fsm (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .instr_valid_i          (instr_valid_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .jump_in_dec_i          (jump_in_dec_i),
    .eret_insn_i            (eret_insn_i),
    .pipe_flush_i           (pipe_flush_i),
    .exc_req_i              (exc_req_i),
    .ext_req_i              (ext_req_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .jr_stall_i             (jr_stall_o),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding_o),
    .instr_req_o            (instr_req_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o)
  );

  hazard_detect #(
    .N_OPERANDS (N_OPERANDS)
  ) u_hazard (
    .is_decoding_i       (is_decoding_o),
    .illegal_insn_i      (illegal_insn_i),
    .data_req_ex_i       (data_req_ex_i),
    .regfile_we_ex_i     (regfile_we_ex_i),
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .jump_in_dec_i       (jump_in_dec_i),
    .reg_d_ex_match_i    (reg_d_ex_match_i),
    .reg_d_wb_match_i    (reg_d_wb_match_i),
    .reg_d_alu_match_i   (reg_d_alu_match_i),
    .load_stall_o        (load_stall_o),
    .jr_stall_o          (jr_stall_o),
    .deassert_we_o       (deassert_we_o)
  );

  operand_forward #(
    .N_OPERANDS (N_OPERANDS)
  ) u_fwd (
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .reg_d_wb_match_i    (reg_d_wb_match_i),
    .reg_d_alu_match_i   (reg_d_alu_match_i),
    .data_misaligned_i   (data_misaligned_i),
    .mult_multicycle_i   (mult_multicycle_i),
    .operand_fw_sel_o    (operand_fw_sel_o)
  );

endmodule

`default_nettype wire

//--- hdl/ctrl_fsm.sv
// main control FSM of the core: boot, decode, jumps, taken branches,
// exception entry and return, and the flush that leads into sleep
`timescale 1ns/100ps
`default_nettype none

module ctrl_fsm (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         fetch_enable_i,
  input  wire logic         instr_valid_i,
  input  wire logic         branch_taken_ex_i,
  input  ctrl_pkg::jump_e   jump_in_dec_i,
  input  wire logic         eret_insn_i,
  input  wire logic         pipe_flush_i,
  input  wire logic         exc_req_i,
  input  wire logic         ext_req_i,
  input  wire logic         id_ready_i,
  input  wire logic         ex_valid_i,
  input  wire logic         jr_stall_i,
  output logic              ctrl_busy_o,
  output logic              is_decoding_o,
  output logic              instr_req_o,
  output logic              pc_set_o,
  output ctrl_pkg::pc_mux_e pc_mux_o,
  output logic              exc_ack_o,
  output logic              exc_save_if_o,
  output logic              exc_save_id_o,
  output logic              exc_save_takenbranch_o,
  output logic              exc_restore_id_o,
  output logic              halt_if_o,
  output logic              halt_id_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set once a jump or eret has redirected fetch, held while ID stalls
  logic jump_done;
  logic jump_done_q;

  logic jump_in_dec;

  assign jump_in_dec = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // defaults: busy and fetching, nothing redirected
    state_d                = state_q;
    jump_done              = jump_done_q;

    ctrl_busy_o            = 1'b1;
    is_decoding_o          = 1'b0;
    instr_req_o            = 1'b1;

    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;

    exc_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;

    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;

    unique case (state_q)
      // idle after reset until fetch is enabled
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load boot address into the fetch PC, single cycle
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // pipeline empty and stopped, wake on enable or interrupt
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // pending interrupt: nothing in ID yet, so save the IF PC
        if (exc_req_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE: begin
        // instruction in ID only counts when it is not in a branch shadow
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          if (jump_in_dec) begin
            // target already known in ID
            // wait out a jr stall, then redirect once
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end else if (exc_req_i) begin
            // take the exception on this instruction, keep it out of EX
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            exc_save_id_o = 1'b1;
            halt_id_o     = 1'b1;
          end

          // return from exception
          if (eret_insn_i) begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q) begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end

          // wfi, or eret back into sleep: drain EX and WB first
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // bubble in ID: external request saves the IF PC
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
          halt_id_o     = 1'b1;
        end

        // taken branch in EX wins over whatever sits in ID
        if (branch_taken_ex_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_BRANCH;
          is_decoding_o = 1'b0;
          // interrupt right at the branch: resume at the branch target
          if (ext_req_i) begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
            halt_id_o              = 1'b1;
          end
        end
      end

      // let the last instruction leave EX
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // one cycle for WB, then resume or sleep
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end else begin
          state_d   = SLEEP;
        end
      end

      // unused encoding, fall back to reset state
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // flag drops as soon as ID accepts the next instruction
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/operand_forward.sv
// forwarding source select for each register operand in ID, with the
// misaligned access and multicycle multiply overrides on top
`timescale 1ns/100ps
`default_nettype none

module operand_forward #(
  parameter int N_OPERANDS = 3
) (
  input  wire logic                          regfile_we_wb_i,
  input  wire logic                          regfile_alu_we_fw_i,
  input  wire logic [N_OPERANDS-1:0]         reg_d_wb_match_i,
  input  wire logic [N_OPERANDS-1:0]         reg_d_alu_match_i,
  input  wire logic                          data_misaligned_i,
  input  wire logic                          mult_multicycle_i,
  output ctrl_pkg::fw_sel_e [N_OPERANDS-1:0] operand_fw_sel_o
);

  import ctrl_pkg::*;

  // one selector per operand, override role fixed by operand index
  for (genvar k = 0; k < N_OPERANDS; k++) begin : g_operand

    always_comb begin
      // plain priority: EX result is newer than WB result
      if (regfile_alu_we_fw_i && reg_d_alu_match_i[k]) begin
        operand_fw_sel_o[k] = SEL_FW_EX;
      end else if (regfile_we_wb_i && reg_d_wb_match_i[k]) begin
        operand_fw_sel_o[k] = SEL_FW_WB;
      end else begin
        operand_fw_sel_o[k] = SEL_REGFILE;
      end

      // second half of a misaligned access
      // A takes the incremented address from EX, B rereads the store data
      if (data_misaligned_i) begin
        if (k == 0) begin
          operand_fw_sel_o[k] = SEL_FW_EX;
        end else if (k == 1) begin
          operand_fw_sel_o[k] = SEL_REGFILE;
        end
      end else if (mult_multicycle_i && (k == 2)) begin
        // multiplier keeps its partial result on the C path
        operand_fw_sel_o[k] = SEL_FW_EX;
      end
    end

  end

endmodule

`default_nettype wire

//--- hdl/hazard_detect.sv
// hazard detection for the instruction in ID: load-use and jump-register
// stalls, plus the write enable kill sent back to the decoder
`timescale 1ns/100ps
`default_nettype none

module hazard_detect #(
  parameter int N_OPERANDS = 3
) (
  input  wire logic                  is_decoding_i,
  input  wire logic                  illegal_insn_i,
  input  wire logic                  data_req_ex_i,
  input  wire logic                  regfile_we_ex_i,
  input  wire logic                  regfile_we_wb_i,
  input  wire logic                  regfile_alu_we_fw_i,
  input  ctrl_pkg::jump_e            jump_in_dec_i,
  input  wire logic [N_OPERANDS-1:0] reg_d_ex_match_i,
  input  wire logic [N_OPERANDS-1:0] reg_d_wb_match_i,
  input  wire logic [N_OPERANDS-1:0] reg_d_alu_match_i,
  output logic                       load_stall_o,
  output logic                       jr_stall_o,
  output logic                       deassert_we_o
);

  import ctrl_pkg::*;

  logic jalr_in_dec;
  logic ra_pending_wb;
  logic ra_pending_ex;
  logic ra_pending_alu;

  ////////////////////////////////////////////////////////////////////////////
  // load-use
  ////////////////////////////////////////////////////////////////////////////

  // a load sits in EX and its destination is read by any operand in ID
  // data only arrives in WB, so ID has to wait one cycle
  assign load_stall_o = data_req_ex_i & regfile_we_ex_i & (|reg_d_ex_match_i);

  ////////////////////////////////////////////////////////////////////////////
  // jump register
  ////////////////////////////////////////////////////////////////////////////

  assign jalr_in_dec = (jump_in_dec_i == BRANCH_JALR);

  // target address is computed in ID straight from the regfile port
  // so any write still in flight to operand A blocks the jump
  assign ra_pending_wb  = regfile_we_wb_i     & reg_d_wb_match_i[0];
  assign ra_pending_ex  = regfile_we_ex_i     & reg_d_ex_match_i[0];
  assign ra_pending_alu = regfile_alu_we_fw_i & reg_d_alu_match_i[0];

  assign jr_stall_o = jalr_in_dec & (ra_pending_wb | ra_pending_ex | ra_pending_alu);

  ////////////////////////////////////////////////////////////////////////////
  // write enable kill
  ////////////////////////////////////////////////////////////////////////////

  // instruction in ID must not write back when
  // - the FSM is not decoding it
  // - it is illegal
  // - it is held back by a stall and will be reissued
  assign deassert_we_o = ~is_decoding_i | illegal_insn_i | load_stall_o | jr_stall_o;

endmodule

`default_nettype wire

//--- hdl/ctrl_pkg.sv
// shared encodings for the core controller: FSM states, PC source, operand
// forwarding source, jump kind and the default register operand count
`default_nettype none

package ctrl_pkg;

  // register operands seen by ID
  // 0 is A (jump register), 1 is B (misaligned second access), 2 is C (mult storage)
  parameter int N_OPERANDS = 3;

  // controller FSM states
  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    SLEEP       = 3'd2,
    FIRST_FETCH = 3'd3,
    DECODE      = 3'd4,
    FLUSH_EX    = 3'd5,
    FLUSH_WB    = 3'd6
  } ctrl_state_e;

  // PC source for the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // operand source in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_WB   = 2'b01,
    SEL_FW_EX   = 2'b10
  } fw_sel_e;

  // jump kind as reported by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_e;

endpackage

`default_nettype wire
